// File: Makefile
# Verilator build and run of the max-pooling core testbench

VERILATOR ?= verilator
TOP       ?= pool_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= list.f

SRCS := $(wildcard design/*.sv) $(wildcard test/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Checks failed" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/feat_gather.sv
// Issues grps*k feature reads per point, group-major, neighbor-minor
// Addresses wrap at 16 bits

module feat_gather import pool_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             gather_start,
    input  k_t               k,
    input  grp_t             grps,
    input  idx_t             feat_base,
    input  idx_t [K_MAX-1:0] nb_idx,
    output logic             feat_addr_vld,
    input  logic             feat_addr_rdy,
    output idx_t             feat_addr
);

    nb_t  nb_cnt;
    grp_t grp_cnt;
    logic active;
    logic fire;
    logic last_nb;
    logic last_grp;

    assign feat_addr_vld = active;
    assign fire          = feat_addr_vld && feat_addr_rdy;
    assign last_nb       = (k_t'(nb_cnt) == k - k_t'(1));
    assign last_grp      = (grp_cnt == grps - grp_t'(1));

    // Feature rows are grps words long
    assign feat_addr = feat_base + idx_t'(nb_idx[nb_cnt] * grps) + idx_t'(grp_cnt);

    // ======================================================================
    // Nested neighbor / group counters
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else if (gather_start) begin
            active  <= 1'b1;
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else if (fire) begin
            if (last_nb) begin
                nb_cnt <= '0;
                if (last_grp) begin
                    active <= 1'b0;
                end else begin
                    grp_cnt <= grp_cnt + grp_t'(1);
                end
            end else begin
                nb_cnt <= nb_cnt + nb_t'(1);
            end
        end
    end

endmodule

// File: design/map_fetch.sv
// Map memory must answer in request order; any number may be outstanding
// nb_idx is valid only after fetch_done, until the next fetch_start

module map_fetch import pool_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_start,
    input  k_t                   k,
    input  idx_t                 cp,
    input  idx_t                 map_base,
    output logic                 map_addr_vld,
    input  logic                 map_addr_rdy,
    output idx_t                 map_addr,
    input  logic                 map_dat_vld,
    input  idx_t                 map_dat,
    output logic                 map_dat_rdy,
    output logic                 fetch_done,
    output idx_t [K_MAX-1:0]     nb_idx
);

    k_t   req_cnt;
    k_t   rsp_cnt;
    logic active;
    logic req_fire;
    logic rsp_fire;

    // Requests run ahead of responses
    assign map_addr_vld = active && (req_cnt < k);
    assign map_addr     = map_base + idx_t'(cp * K_MAX) + idx_t'(req_cnt);
    assign map_dat_rdy  = active && (rsp_cnt < k);
    assign req_fire     = map_addr_vld && map_addr_rdy;
    assign rsp_fire     = map_dat_vld && map_dat_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            req_cnt    <= '0;
            rsp_cnt    <= '0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (fetch_start) begin
                active  <= 1'b1;
                req_cnt <= '0;
                rsp_cnt <= '0;
            end else begin
                if (req_fire) begin
                    req_cnt <= req_cnt + k_t'(1);
                end
                if (rsp_fire) begin
                    rsp_cnt <= rsp_cnt + k_t'(1);
                    // Last index in, all requests already issued
                    if (rsp_cnt == k - k_t'(1)) begin
                        active     <= 1'b0;
                        fetch_done <= 1'b1;
                    end
                end
            end
        end
    end

    // Index register file, slot n holds neighbor n
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            nb_idx[rsp_cnt[NB_W-1:0]] <= map_dat;
        end
    end

endmodule

// File: design/max_reduce.sv
// Feature data must come back in the order feat_gather issued it
// One pending result at a time; input stalls while it waits on out_rdy

module max_reduce import pool_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic gather_start,
    input  k_t   k,
    input  grp_t grps,
    input  idx_t cp,
    input  idx_t out_base,
    input  logic feat_dat_vld,
    input  feat_t feat_dat,
    output logic feat_dat_rdy,
    output logic out_vld,
    input  logic out_rdy,
    output idx_t out_addr,
    output feat_t out_dat,
    output logic point_done
);

    nb_t   nb_cnt;
    grp_t  grp_cnt;
    logic  active;
    logic  in_fire;
    logic  out_fire;
    logic  last_grp;
    feat_t max_q;
    feat_t merged;

    assign feat_dat_rdy = active && !out_vld;
    assign in_fire      = feat_dat_vld && feat_dat_rdy;
    assign out_fire     = out_vld && out_rdy;
    assign last_grp     = (grp_cnt == grps - grp_t'(1));
    assign point_done   = out_fire && last_grp;

    assign out_addr = out_base + idx_t'(cp * grps) + idx_t'(grp_cnt);
    assign out_dat  = max_q;

    // First neighbor loads, later ones keep the larger lane
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (nb_cnt == '0 || feat_dat[l] > max_q[l]) begin
                merged[l] = feat_dat[l];
            end else begin
                merged[l] = max_q[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            max_q <= merged;
        end
    end

    // ======================================================================
    // Return counters and write handshake
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            out_vld <= 1'b0;
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else if (gather_start) begin
            active  <= 1'b1;
            nb_cnt  <= '0;
            grp_cnt <= '0;
        end else begin
            if (in_fire) begin
                if (k_t'(nb_cnt) == k - k_t'(1)) begin
                    nb_cnt  <= '0;
                    out_vld <= 1'b1;
                end else begin
                    nb_cnt <= nb_cnt + nb_t'(1);
                end
            end
            if (out_fire) begin
                out_vld <= 1'b0;
                if (last_grp) begin
                    active <= 1'b0;
                end else begin
                    grp_cnt <= grp_cnt + grp_t'(1);
                end
            end
        end
    end

endmodule

// File: design/pool_ctrl.sv
// Points run strictly one after another, no overlap between them
// num_points and grps must be at least 1, k in 1..8

module pool_ctrl import pool_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_vld,
    output logic cfg_rdy,
    input  idx_t cfg_num_points,
    input  k_t   cfg_k,
    input  grp_t cfg_grps,
    input  idx_t cfg_map_base,
    input  idx_t cfg_feat_base,
    input  idx_t cfg_out_base,
    input  logic fetch_done,
    input  logic point_done,
    output logic fetch_start,
    output logic gather_start,
    output k_t   k,
    output grp_t grps,
    output idx_t cp,
    output idx_t map_base,
    output idx_t feat_base,
    output idx_t out_base
);

    pool_state_e state;
    idx_t        num_points;
    logic        cfg_acc;
    logic        last_point;

    assign cfg_rdy    = (state == IDLE);
    assign cfg_acc    = cfg_vld && cfg_rdy;
    assign last_point = (cp == num_points - idx_t'(1));

    // Configuration capture
    always_ff @(posedge clk) begin
        if (cfg_acc) begin
            num_points <= cfg_num_points;
            k          <= cfg_k;
            grps       <= cfg_grps;
            map_base   <= cfg_map_base;
            feat_base  <= cfg_feat_base;
            out_base   <= cfg_out_base;
        end
    end

    // ======================================================================
    // Per-point sequencing
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            cp           <= '0;
            fetch_start  <= 1'b0;
            gather_start <= 1'b0;
        end else begin
            fetch_start  <= 1'b0;
            gather_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (cfg_acc) begin
                        state       <= MAP_FETCH;
                        cp          <= '0;
                        fetch_start <= 1'b1;
                    end
                end
                MAP_FETCH: begin
                    // Index table complete, start streaming features
                    if (fetch_done) begin
                        state        <= GATHER;
                        gather_start <= 1'b1;
                    end
                end
                GATHER: begin
                    if (point_done) begin
                        if (last_point) begin
                            state <= IDLE;
                        end else begin
                            cp          <= cp + idx_t'(1);
                            state       <= MAP_FETCH;
                            fetch_start <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: design/pool_pkg.sv
// Shared widths and types for the max-pooling core
// Feature words are LANES unsigned activations, lane 0 in the low byte

package pool_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int IDX_W = 16;
    localparam int ACT_W = 8;
    localparam int LANES = 4;
    localparam int K_MAX = 8;
    localparam int K_W   = 4;
    localparam int NB_W  = 3;
    localparam int GRP_W = 8;

    // ======================================================================
    // Types
    // ======================================================================
    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [ACT_W-1:0] act_t;
    typedef act_t [LANES-1:0] feat_t;

    // Neighbor count holds 1..K_MAX, slot number 0..K_MAX-1
    typedef logic [K_W-1:0]   k_t;
    typedef logic [NB_W-1:0]  nb_t;
    typedef logic [GRP_W-1:0] grp_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_FETCH,
        GATHER
    } pool_state_e;

endpackage

// File: design/pool_top.sv
// Single max-pooling core, one output point in flight at a time
// Both memories must return read data in request order

module pool_top import pool_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // Configuration
    input  logic  cfg_vld,
    output logic  cfg_rdy,
    input  idx_t  cfg_num_points,
    input  k_t    cfg_k,
    input  grp_t  cfg_grps,
    input  idx_t  cfg_map_base,
    input  idx_t  cfg_feat_base,
    input  idx_t  cfg_out_base,
    // Map read
    output logic  map_addr_vld,
    input  logic  map_addr_rdy,
    output idx_t  map_addr,
    input  logic  map_dat_vld,
    input  idx_t  map_dat,
    output logic  map_dat_rdy,
    // Feature read
    output logic  feat_addr_vld,
    input  logic  feat_addr_rdy,
    output idx_t  feat_addr,
    input  logic  feat_dat_vld,
    input  feat_t feat_dat,
    output logic  feat_dat_rdy,
    // Result write
    output logic  out_vld,
    input  logic  out_rdy,
    output idx_t  out_addr,
    output feat_t out_dat
);

    logic             fetch_start;
    logic             gather_start;
    logic             fetch_done;
    logic             point_done;
    k_t               k;
    grp_t             grps;
    idx_t             cp;
    idx_t             map_base;
    idx_t             feat_base;
    idx_t             out_base;
    idx_t [K_MAX-1:0] nb_idx;

    pool_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_vld        (cfg_vld),
        .cfg_rdy        (cfg_rdy),
        .cfg_num_points (cfg_num_points),
        .cfg_k          (cfg_k),
        .cfg_grps       (cfg_grps),
        .cfg_map_base   (cfg_map_base),
        .cfg_feat_base  (cfg_feat_base),
        .cfg_out_base   (cfg_out_base),
        .fetch_done     (fetch_done),
        .point_done     (point_done),
        .fetch_start    (fetch_start),
        .gather_start   (gather_start),
        .k              (k),
        .grps           (grps),
        .cp             (cp),
        .map_base       (map_base),
        .feat_base      (feat_base),
        .out_base       (out_base)
    );

    map_fetch u_map_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_start  (fetch_start),
        .k            (k),
        .cp           (cp),
        .map_base     (map_base),
        .map_addr_vld (map_addr_vld),
        .map_addr_rdy (map_addr_rdy),
        .map_addr     (map_addr),
        .map_dat_vld  (map_dat_vld),
        .map_dat      (map_dat),
        .map_dat_rdy  (map_dat_rdy),
        .fetch_done   (fetch_done),
        .nb_idx       (nb_idx)
    );

    feat_gather u_feat_gather (
        .clk           (clk),
        .rst_n         (rst_n),
        .gather_start  (gather_start),
        .k             (k),
        .grps          (grps),
        .feat_base     (feat_base),
        .nb_idx        (nb_idx),
        .feat_addr_vld (feat_addr_vld),
        .feat_addr_rdy (feat_addr_rdy),
        .feat_addr     (feat_addr)
    );

    max_reduce u_max_reduce (
        .clk          (clk),
        .rst_n        (rst_n),
        .gather_start (gather_start),
        .k            (k),
        .grps         (grps),
        .cp           (cp),
        .out_base     (out_base),
        .feat_dat_vld (feat_dat_vld),
        .feat_dat     (feat_dat),
        .feat_dat_rdy (feat_dat_rdy),
        .out_vld      (out_vld),
        .out_rdy      (out_rdy),
        .out_addr     (out_addr),
        .out_dat      (out_dat),
        .point_done   (point_done)
    );

endmodule

// File: list.f
design/pool_pkg.sv
design/pool_ctrl.sv
design/map_fetch.sv
design/feat_gather.sv
design/max_reduce.sv
design/pool_top.sv
test/pool_properties.sv
test/pool_tb.sv

// File: test/pool_properties.sv
// Handshake rules on the pool_top ports, bound into the DUT
// All checks are off while rst_n is low

module pool_properties import pool_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  cfg_rdy,
    input logic  map_addr_vld,
    input logic  map_addr_rdy,
    input idx_t  map_addr,
    input logic  feat_addr_vld,
    input logic  feat_addr_rdy,
    input idx_t  feat_addr,
    input logic  out_vld,
    input logic  out_rdy,
    input idx_t  out_addr,
    input feat_t out_dat
);

    // Pending result keeps its payload
    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_vld && !out_rdy |=> out_vld && $stable(out_addr) && $stable(out_dat))
        else $error("out_vld dropped or payload changed before out_rdy");

    feat_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        feat_addr_vld && !feat_addr_rdy |=> feat_addr_vld && $stable(feat_addr))
        else $error("feat_addr_vld dropped or address changed before feat_addr_rdy");

    map_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        map_addr_vld && !map_addr_rdy |=> map_addr_vld && $stable(map_addr))
        else $error("map_addr_vld dropped or address changed before map_addr_rdy");

    // No writes outside a run
    idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_rdy |-> !out_vld)
        else $error("out_vld high while the core is idle");

endmodule

// File: test/pool_tb.sv
// Memories answer in request order with random stalls, indices stay below 64
// Map and feature memories hold 1024 words, addressed by the low 10 bits

module pool_tb import pool_pkg::*; ();

    localparam int NUM_CFG  = 5;
    localparam int MEM_W    = 10;
    localparam int MEM_SIZE = 1 << MEM_W;

    typedef struct {
        idx_t num_points;
        k_t   k;
        grp_t grps;
        idx_t map_base;
        idx_t feat_base;
        idx_t out_base;
        logic stall;
    } cfg_entry_t;

    logic  clk;
    logic  rst_n;
    logic  cfg_vld;
    logic  cfg_rdy;
    idx_t  cfg_num_points;
    k_t    cfg_k;
    grp_t  cfg_grps;
    idx_t  cfg_map_base;
    idx_t  cfg_feat_base;
    idx_t  cfg_out_base;
    logic  map_addr_vld;
    logic  map_addr_rdy;
    idx_t  map_addr;
    logic  map_dat_vld;
    idx_t  map_dat;
    logic  map_dat_rdy;
    logic  feat_addr_vld;
    logic  feat_addr_rdy;
    idx_t  feat_addr;
    logic  feat_dat_vld;
    feat_t feat_dat;
    logic  feat_dat_rdy;
    logic  out_vld;
    logic  out_rdy;
    idx_t  out_addr;
    feat_t out_dat;

    cfg_entry_t  cfg_table [NUM_CFG];
    idx_t        map_mem [MEM_SIZE];
    feat_t       feat_mem [MEM_SIZE];
    idx_t        map_q [$];
    feat_t       feat_q [$];
    idx_t        exp_map_addr [$];
    idx_t        exp_feat_addr [$];
    idx_t        exp_out_addr [$];
    feat_t       exp_out_dat [$];
    logic        stall;
    logic        map_d_fire;
    logic        feat_d_fire;
    integer      seed;
    logic [31:0] rnd;
    int          limit;
    int          cycles;

    pool_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_vld        (cfg_vld),
        .cfg_rdy        (cfg_rdy),
        .cfg_num_points (cfg_num_points),
        .cfg_k          (cfg_k),
        .cfg_grps       (cfg_grps),
        .cfg_map_base   (cfg_map_base),
        .cfg_feat_base  (cfg_feat_base),
        .cfg_out_base   (cfg_out_base),
        .map_addr_vld   (map_addr_vld),
        .map_addr_rdy   (map_addr_rdy),
        .map_addr       (map_addr),
        .map_dat_vld    (map_dat_vld),
        .map_dat        (map_dat),
        .map_dat_rdy    (map_dat_rdy),
        .feat_addr_vld  (feat_addr_vld),
        .feat_addr_rdy  (feat_addr_rdy),
        .feat_addr      (feat_addr),
        .feat_dat_vld   (feat_dat_vld),
        .feat_dat       (feat_dat),
        .feat_dat_rdy   (feat_dat_rdy),
        .out_vld        (out_vld),
        .out_rdy        (out_rdy),
        .out_addr       (out_addr),
        .out_dat        (out_dat)
    );

    bind pool_top pool_properties u_props (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_rdy       (cfg_rdy),
        .map_addr_vld  (map_addr_vld),
        .map_addr_rdy  (map_addr_rdy),
        .map_addr      (map_addr),
        .feat_addr_vld (feat_addr_vld),
        .feat_addr_rdy (feat_addr_rdy),
        .feat_addr     (feat_addr),
        .out_vld       (out_vld),
        .out_rdy       (out_rdy),
        .out_addr      (out_addr),
        .out_dat       (out_dat)
    );

    // ======================================================================
    // Error handling and compare tasks
    // ======================================================================
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_idx(input string name, input idx_t got, input idx_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_feat(input string name, input feat_t got, input feat_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic require_pending(input int left, input string what);
        if (left == 0) begin
            $display("Unexpected %s at t=%0t, nothing more was expected", what, $time);
            abort_run();
        end
    endtask

    function automatic logic [MEM_W-1:0] mem_index(input idx_t addr);
        return addr[MEM_W-1:0];
    endfunction

    // Each row holds num_points, k, grps, map_base, feat_base, out_base and stall
    task automatic load_table();
        cfg_table[0] = '{16'd4, 4'd1, 8'd1, 16'h0000, 16'h0000, 16'h0300, 1'b0};
        cfg_table[1] = '{16'd5, 4'd8, 8'd3, 16'h0028, 16'h0010, 16'h0310, 1'b0};
        cfg_table[2] = '{16'd5, 4'd8, 8'd3, 16'h0028, 16'h0010, 16'h0310, 1'b1};
        cfg_table[3] = '{16'd6, 4'd3, 8'd2, 16'h0080, 16'h0100, 16'h0340, 1'b1};
        cfg_table[4] = '{16'd3, 4'd5, 8'd4, 16'h0010, 16'h0040, 16'h0360, 1'b1};
    endtask

    // ======================================================================
    // Reference model of the reads and writes in order
    // ======================================================================
    task automatic build_expected(input cfg_entry_t c);
        idx_t  nb;
        idx_t  addr;
        feat_t word;
        feat_t best;
        for (int p = 0; p < int'(c.num_points); p++) begin
            for (int n = 0; n < int'(c.k); n++) begin
                exp_map_addr.push_back(c.map_base + idx_t'(p * K_MAX + n));
            end
            for (int g = 0; g < int'(c.grps); g++) begin
                for (int n = 0; n < int'(c.k); n++) begin
                    nb   = map_mem[mem_index(c.map_base + idx_t'(p * K_MAX + n))];
                    addr = c.feat_base + idx_t'(int'(nb) * int'(c.grps) + g);
                    exp_feat_addr.push_back(addr);
                    word = feat_mem[mem_index(addr)];
                    for (int l = 0; l < LANES; l++) begin
                        if (n == 0 || word[l] > best[l]) begin
                            best[l] = word[l];
                        end
                    end
                end
                exp_out_addr.push_back(c.out_base + idx_t'(p * int'(c.grps) + g));
                exp_out_dat.push_back(best);
            end
        end
    endtask

    task automatic run_config(input int idx);
        cfg_entry_t c;
        c = cfg_table[idx];
        build_expected(c);
        @(posedge clk);
        #2;
        stall          = c.stall;
        cfg_vld        = 1'b1;
        cfg_num_points = c.num_points;
        cfg_k          = c.k;
        cfg_grps       = c.grps;
        cfg_map_base   = c.map_base;
        cfg_feat_base  = c.feat_base;
        cfg_out_base   = c.out_base;
        @(negedge clk);
        while (!cfg_rdy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cfg_vld = 1'b0;
        // Run ends when the core is idle again
        @(negedge clk);
        while (!cfg_rdy) begin
            @(negedge clk);
        end
        if (exp_out_addr.size() != 0 || exp_feat_addr.size() != 0 ||
            exp_map_addr.size() != 0) begin
            $display("Configuration %0d went idle with %0d map reads, %0d feature reads %s",
                     idx, exp_map_addr.size(), exp_feat_addr.size(), "or writes missing");
            $display("Writes still missing: %0d", exp_out_addr.size());
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // Memory models and ready drivers
    // ======================================================================
    initial begin
        map_addr_rdy  = 1'b0;
        map_dat_vld   = 1'b0;
        map_dat       = '0;
        feat_addr_rdy = 1'b0;
        feat_dat_vld  = 1'b0;
        feat_dat      = '0;
        out_rdy       = 1'b0;
        seed          = 9931;
        for (int i = 0; i < MEM_SIZE; i++) begin
            rnd         = $random(seed);
            map_mem[i]  = idx_t'(rnd[5:0]);
            rnd         = $random(seed);
            feat_mem[i] = feat_t'(rnd);
        end
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            rnd           = $random(seed);
            map_addr_rdy  = !stall || (rnd[1:0] != 2'b00);
            feat_addr_rdy = !stall || (rnd[3:2] != 2'b00);
            out_rdy       = !stall || (rnd[5:4] != 2'b00);
            // Data valid holds until taken
            if (!map_dat_vld || map_d_fire) begin
                map_dat_vld = (map_q.size() > 0) && (!stall || rnd[6]);
                map_dat     = map_dat_vld ? map_q[0] : '0;
            end
            if (!feat_dat_vld || feat_d_fire) begin
                feat_dat_vld = (feat_q.size() > 0) && (!stall || rnd[7]);
                feat_dat     = feat_dat_vld ? feat_q[0] : '0;
            end
        end
    end

    // Transfers seen at the falling edge happen on the next rising edge
    initial begin
        map_d_fire  = 1'b0;
        feat_d_fire = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                map_d_fire  = map_dat_vld && map_dat_rdy;
                feat_d_fire = feat_dat_vld && feat_dat_rdy;
                if (map_d_fire) begin
                    void'(map_q.pop_front());
                end
                if (feat_d_fire) begin
                    void'(feat_q.pop_front());
                end
                if (map_addr_vld && map_addr_rdy) begin
                    require_pending(exp_map_addr.size(), "map read");
                    check_idx("map_addr", map_addr, exp_map_addr.pop_front());
                    map_q.push_back(map_mem[mem_index(map_addr)]);
                end
                if (feat_addr_vld && feat_addr_rdy) begin
                    require_pending(exp_feat_addr.size(), "feature read");
                    check_idx("feat_addr", feat_addr, exp_feat_addr.pop_front());
                    feat_q.push_back(feat_mem[mem_index(feat_addr)]);
                end
                if (out_vld && out_rdy) begin
                    require_pending(exp_out_addr.size(), "result write");
                    check_idx("out_addr", out_addr, exp_out_addr.pop_front());
                    check_feat("out_dat", out_dat, exp_out_dat.pop_front());
                end
            end
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: run did not finish within %0d cycles", limit);
                abort_run();
            end
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        rst_n          = 1'b0;
        cfg_vld        = 1'b0;
        cfg_num_points = '0;
        cfg_k          = '0;
        cfg_grps       = '0;
        cfg_map_base   = '0;
        cfg_feat_base  = '0;
        cfg_out_base   = '0;
        stall          = 1'b0;
        load_table();
        // 40 cycles per feature read plus margin
        limit = 1000;
        for (int i = 0; i < NUM_CFG; i++) begin
            limit += 40 * int'(cfg_table[i].num_points) * int'(cfg_table[i].k) *
                     int'(cfg_table[i].grps);
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        check_bit("map_addr_vld", map_addr_vld, 1'b0);
        check_bit("feat_addr_vld", feat_addr_vld, 1'b0);
        check_bit("out_vld", out_vld, 1'b0);
        check_bit("map_dat_rdy", map_dat_rdy, 1'b0);
        check_bit("feat_dat_rdy", feat_dat_rdy, 1'b0);
        for (int i = 0; i < NUM_CFG; i++) begin
            run_config(i);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
